// File: hw/ym_timer_pkg.sv
package ym_timer_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register map.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [7:0] ADDR_TA_HI = 8'h24;
	localparam logic [7:0] ADDR_TA_LO = 8'h25;
	localparam logic [7:0] ADDR_TB    = 8'h26;
	localparam logic [7:0] ADDR_CTRL  = 8'h27;

	// Timer A counts 24 ticks per step of its 10-bit counter.
	localparam int TA_WIDTH      = 10;
	localparam int TA_MULT_WIDTH = 5;
	localparam int TA_MULT_MAX   = 23;

	// Timer B counts 384 ticks per step of its 8-bit counter.
	localparam int TB_WIDTH      = 8;
	localparam int TB_MULT_WIDTH = 9;
	localparam int TB_MULT_MAX   = 383;

	// Synthesis tick comes every PRESCALE clk cycles.
	localparam int PRESCALE       = 6;
	localparam int PRESCALE_WIDTH = 3;
	localparam logic [PRESCALE_WIDTH-1:0] PRESCALE_LAST = PRESCALE_WIDTH'(PRESCALE - 1);

	// Bit positions inside the control byte.
	localparam int CTRL_RUN_A    = 0;
	localparam int CTRL_RUN_B    = 1;
	localparam int CTRL_IRQ_EN_A = 2;
	localparam int CTRL_IRQ_EN_B = 3;
	localparam int CTRL_CLR_A    = 4;
	localparam int CTRL_CLR_B    = 5;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Grouped signals.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic [TA_WIDTH-1:0] value_a;
		logic [TB_WIDTH-1:0] value_b;
	} timer_values_t;

	typedef struct packed {
		logic run_a;
		logic run_b;
		logic irq_en_a;
		logic irq_en_b;
	} timer_ctrl_t;

	// Status byte as the host sees it.
	typedef struct packed {
		logic [5:0] reserved;
		logic       flag_b;
		logic       flag_a;
	} status_t;

endpackage

// File: hw/ym_reg_decoder.sv
`timescale 1ns/1ns

module ym_reg_decoder (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         wr,
	input  logic [7:0]                   addr,
	input  logic [7:0]                   din,
	output ym_timer_pkg::timer_values_t  values,
	output ym_timer_pkg::timer_ctrl_t    ctrl,
	output logic                         clr_a,
	output logic                         clr_b
);

	// Write strobes per register.
	logic wr_ta_hi;
	logic wr_ta_lo;
	logic wr_tb;
	logic wr_ctrl;

	assign wr_ta_hi = wr && (addr == ym_timer_pkg::ADDR_TA_HI);
	assign wr_ta_lo = wr && (addr == ym_timer_pkg::ADDR_TA_LO);
	assign wr_tb    = wr && (addr == ym_timer_pkg::ADDR_TB);
	assign wr_ctrl  = wr && (addr == ym_timer_pkg::ADDR_CTRL);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Load values.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Timer A is split over two writes.
	// High byte holds bits 9:2, the low register only bits 1:0.
	always_ff @(posedge clk) begin
		if (wr_ta_hi) begin
			values.value_a[9:2] <= din;
		end
		if (wr_ta_lo) begin
			values.value_a[1:0] <= din[1:0];
		end
		if (wr_tb) begin
			values.value_b <= din;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control byte.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Run and enable bits are levels and stay until rewritten.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctrl <= '0;
		end else if (wr_ctrl) begin
			ctrl.run_a    <= din[ym_timer_pkg::CTRL_RUN_A];
			ctrl.run_b    <= din[ym_timer_pkg::CTRL_RUN_B];
			ctrl.irq_en_a <= din[ym_timer_pkg::CTRL_IRQ_EN_A];
			ctrl.irq_en_b <= din[ym_timer_pkg::CTRL_IRQ_EN_B];
		end
	end

	// Clear bits become one-cycle pulses.
	// They are never stored, so a later write need not reset them.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			clr_a <= 1'b0;
			clr_b <= 1'b0;
		end else begin
			clr_a <= wr_ctrl && din[ym_timer_pkg::CTRL_CLR_A];
			clr_b <= wr_ctrl && din[ym_timer_pkg::CTRL_CLR_B];
		end
	end

endmodule

// File: hw/ym_clk_prescaler.sv
`timescale 1ns/1ns

module ym_clk_prescaler (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	// Modulo-PRESCALE phase counter.
	logic [ym_timer_pkg::PRESCALE_WIDTH-1:0] phase;

	// Wraps to zero after the last phase.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (phase == ym_timer_pkg::PRESCALE_LAST) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// One cycle high in the last phase.
	// Both timers share this enable.
	assign tick = (phase == ym_timer_pkg::PRESCALE_LAST);

endmodule

// File: hw/ym_timer.sv
`timescale 1ns/1ns

module ym_timer #(
	parameter int WIDTH      = 10,
	parameter int MULT_WIDTH = 5,
	parameter int MULT_MAX   = 23
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             tick,
	input  logic             hold,
	input  logic [WIDTH-1:0] start_value,
	output logic             overflow
);

	localparam logic [MULT_WIDTH-1:0] MULT_LAST = MULT_WIDTH'(MULT_MAX);

	// Sub-tick multiplier and main counter.
	logic [MULT_WIDTH-1:0] mult;
	logic [WIDTH-1:0]      cnt;

	// Carry conditions of both stages.
	logic mult_done;
	logic cnt_full;

	assign mult_done = (mult == MULT_LAST);
	assign cnt_full  = &cnt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Carry out of the main counter.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Only one tick sees the final state, so this is a single-cycle pulse.
	// Hold masks it in the cycle where the run bit drops.
	assign overflow = tick && !hold && mult_done && cnt_full;

	always_ff @(posedge clk) begin
		if (!rst_n || hold) begin
			// Parked at the load value.
			cnt  <= start_value;
			mult <= '0;
		end else if (tick) begin
			if (overflow) begin
				// Reload for the next period.
				cnt  <= start_value;
				mult <= '0;
			end else if (mult_done) begin
				// Multiplier carries into the counter.
				cnt  <= cnt + 1'b1;
				mult <= '0;
			end else begin
				mult <= mult + 1'b1;
			end
		end
	end

endmodule

// File: hw/ym_irq_status.sv
`timescale 1ns/1ns

module ym_irq_status (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      overflow_a,
	input  logic                      overflow_b,
	input  logic                      clr_a,
	input  logic                      clr_b,
	input  ym_timer_pkg::timer_ctrl_t ctrl,
	output ym_timer_pkg::status_t     status,
	output logic                      irq_n
);

	// Sticky overflow flags.
	logic flag_a;
	logic flag_b;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Flags.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Clear has priority over a set in the same cycle.
	// Enables do not touch the flags.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			if (clr_a) begin
				flag_a <= 1'b0;
			end else if (overflow_a) begin
				flag_a <= 1'b1;
			end
			if (clr_b) begin
				flag_b <= 1'b0;
			end else if (overflow_b) begin
				flag_b <= 1'b1;
			end
		end
	end

	// Interrupt, registered and active low.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			irq_n <= 1'b1;
		end else begin
			irq_n <= !((flag_a && ctrl.irq_en_a) || (flag_b && ctrl.irq_en_b));
		end
	end

	// Status byte, upper bits read as zero.
	always_comb begin
		status          = '0;
		status.flag_a   = flag_a;
		status.flag_b   = flag_b;
	end

endmodule

// File: hw/ym_timer_top.sv
`timescale 1ns/1ns

module ym_timer_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  wr,
	input  logic [7:0]            addr,
	input  logic [7:0]            din,
	output ym_timer_pkg::status_t status,
	output logic                  irq_n,
	output logic                  overflow_a
);

	// Register outputs.
	ym_timer_pkg::timer_values_t values;
	ym_timer_pkg::timer_ctrl_t   ctrl;
	logic                        clr_a;
	logic                        clr_b;

	// Shared synthesis-rate enable.
	logic tick;

	// Timer B overflow stays internal.
	logic overflow_b;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Host side and time base.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	ym_reg_decoder u_decoder (
		.clk    (clk),
		.rst_n  (rst_n),
		.wr     (wr),
		.addr   (addr),
		.din    (din),
		.values (values),
		.ctrl   (ctrl),
		.clr_a  (clr_a),
		.clr_b  (clr_b)
	);

	ym_clk_prescaler u_prescaler (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Timers. A cleared run bit holds the counter.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	ym_timer #(
		.WIDTH      (ym_timer_pkg::TA_WIDTH),
		.MULT_WIDTH (ym_timer_pkg::TA_MULT_WIDTH),
		.MULT_MAX   (ym_timer_pkg::TA_MULT_MAX)
	) timer_a (
		.clk         (clk),
		.rst_n       (rst_n),
		.tick        (tick),
		.hold        (!ctrl.run_a),
		.start_value (values.value_a),
		.overflow    (overflow_a)
	);

	ym_timer #(
		.WIDTH      (ym_timer_pkg::TB_WIDTH),
		.MULT_WIDTH (ym_timer_pkg::TB_MULT_WIDTH),
		.MULT_MAX   (ym_timer_pkg::TB_MULT_MAX)
	) timer_b (
		.clk         (clk),
		.rst_n       (rst_n),
		.tick        (tick),
		.hold        (!ctrl.run_b),
		.start_value (values.value_b),
		.overflow    (overflow_b)
	);

	// Flags and interrupt.
	ym_irq_status u_status (
		.clk        (clk),
		.rst_n      (rst_n),
		.overflow_a (overflow_a),
		.overflow_b (overflow_b),
		.clr_a      (clr_a),
		.clr_b      (clr_b),
		.ctrl       (ctrl),
		.status     (status),
		.irq_n      (irq_n)
	);

endmodule

// File: sim/ym_timer_tb.sv
`timescale 1ns/1ns

module ym_timer_tb;

	// How a row is judged after its control write.
	typedef enum logic [1:0] {
		WATCH,
		FLAG,
		RELOAD,
		SETTLE
	} row_kind_t;

	// One table row with register values, control byte, wait limit and expected results.
	typedef struct packed {
		row_kind_t             kind;
		logic [9:0]            ta;
		logic [7:0]            tb;
		logic [7:0]            ctrl;
		int                    wait_limit;
		ym_timer_pkg::status_t exp_status;
		logic                  exp_irq_n;
		int                    exp_ovf;
	} test_row_t;

	// DUT ports.
	logic                  clk;
	logic                  rst_n;
	logic                  wr;
	logic [7:0]            addr;
	logic [7:0]            din;
	ym_timer_pkg::status_t status;
	logic                  irq_n;
	logic                  overflow_a;

	test_row_t table_rows [9];
	string     test_names [9];

	// Bookkeeping.
	int   cycle_count;
	int   timeout_limit;
	int   ovf_count;
	int   last_ovf_cycle;
	int   pass_count;
	int   fail_count;
	logic row_failed;

	ym_timer_top UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr         (wr),
		.addr       (addr),
		.din        (din),
		.status     (status),
		.irq_n      (irq_n),
		.overflow_a (overflow_a)
	);

	// 100 ns clock.
	always #50 clk = ~clk;

	// Cycle counter and run limit.
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == timeout_limit) begin
			$display("Timeout: the tests did not finish within %0d cycles.", timeout_limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Advance to the next falling edge and note any overflow_a pulse.
	task automatic step();
		@(negedge clk);
		if (overflow_a) begin
			ovf_count++;
			last_ovf_cycle = cycle_count;
		end
	endtask

	// One-cycle host write, called on a falling edge.
	task automatic write_reg(input logic [7:0] reg_addr, input logic [7:0] value);
		wr   = 1'b1;
		addr = reg_addr;
		din  = value;
		step();
		wr = 1'b0;
	endtask

	// Period in clk cycles.
	// Timer A takes 24 ticks per count up to 1024.
	// Timer B takes 384 ticks per count up to 256.
	// Each tick is 6 clk cycles.
	function automatic int period_cycles(input logic use_b, input int value);
		int ticks;
		if (use_b) begin
			ticks = 384 * (256 - value);
		end else begin
			ticks = 24 * (1024 - value);
		end
		return 6 * ticks;
	endfunction

	task automatic report_mismatch(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		$display("ERROR %s: %s expected 0x%0h, actual 0x%0h", name, what, expected, actual);
		row_failed = 1'b1;
	endtask

	task automatic set_row(input int idx, input string name, input row_kind_t kind,
		input logic [9:0] ta, input logic [7:0] tb, input logic [7:0] ctrl,
		input int wait_limit, input logic [7:0] exp_status, input logic exp_irq_n,
		input int exp_ovf);
		test_names[idx] = name;
		table_rows[idx] = '{kind, ta, tb, ctrl, wait_limit, exp_status, exp_irq_n, exp_ovf};
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test table.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control byte bits from bit 0 up are run_a, run_b, irq_en_a, irq_en_b, clr_a and clr_b.
	// Rows run in order and each starts from the state the last one left.
	task automatic load_table();
		set_row(0, "idle", WATCH, 10'd1020, 8'd255, 8'h00, 100, 8'h00, 1'b1, 0);
		set_row(1, "period_a", FLAG, 10'd1020, 8'd255, 8'h01, 700, 8'h01, 1'b1, 1);
		// Timer A stops and its flag is cleared.
		set_row(2, "period_b", FLAG, 10'd1020, 8'd255, 8'h12, 2500, 8'h02, 1'b1, 0);
		set_row(3, "mask_on", SETTLE, 10'd1020, 8'd255, 8'h08, 2, 8'h02, 1'b0, 0);
		set_row(4, "mask_off", SETTLE, 10'd1020, 8'd255, 8'h00, 2, 8'h02, 1'b1, 0);
		set_row(5, "start_a", FLAG, 10'd1020, 8'd255, 8'h21, 700, 8'h01, 1'b1, 1);
		set_row(6, "clear_a", SETTLE, 10'd1020, 8'd255, 8'h11, 2, 8'h00, 1'b1, 0);
		// Next flag counts from the previous overflow to show the reload.
		set_row(7, "reload_a", RELOAD, 10'd1020, 8'd255, 8'h01, 700, 8'h01, 1'b1, 1);
		set_row(8, "hold_a", WATCH, 10'd1022, 8'd255, 8'h30,
			2 * period_cycles(1'b0, 1022), 8'h00, 1'b1, 0);
	endtask

	task automatic run_row(input int idx);
		test_row_t row;
		string     name;
		int        ref_cycle;
		int        period;
		int        elapsed;
		logic      done;
		row        = table_rows[idx];
		name       = test_names[idx];
		row_failed = 1'b0;
		ovf_count  = 0;
		write_reg(ym_timer_pkg::ADDR_TA_HI, row.ta[9:2]);
		write_reg(ym_timer_pkg::ADDR_TA_LO, {6'b0, row.ta[1:0]});
		write_reg(ym_timer_pkg::ADDR_TB, row.tb);
		ref_cycle = (row.kind == RELOAD) ? last_ovf_cycle : cycle_count;
		write_reg(ym_timer_pkg::ADDR_CTRL, row.ctrl);
		done = 1'b0;
		case (row.kind)
			WATCH: begin
				// Let the decoder and status stage settle first.
				step();
				step();
				for (int i = 0; i < row.wait_limit && !done; i++) begin
					step();
					if (status != row.exp_status) begin
						report_mismatch(name, "status", 32'(row.exp_status), 32'(status));
						done = 1'b1;
					end
					if (irq_n != row.exp_irq_n) begin
						report_mismatch(name, "irq_n", 32'(row.exp_irq_n), 32'(irq_n));
						done = 1'b1;
					end
				end
			end
			FLAG, RELOAD: begin
				for (int i = 0; i < row.wait_limit && !done; i++) begin
					step();
					done = (status & row.exp_status) == row.exp_status;
				end
				if (row.exp_status.flag_b) begin
					period = period_cycles(1'b1, int'(row.tb));
				end else begin
					period = period_cycles(1'b0, int'(row.ta));
				end
				elapsed = cycle_count - ref_cycle;
				if (!done) begin
					$display("%s: the flag never rose within %0d cycles.", name, row.wait_limit);
					row_failed = 1'b1;
				end else if (elapsed < period - 6 || elapsed > period + 12) begin
					// One prescale period of start uncertainty plus some slack.
					$display("ERROR %s: flag time expected %0d to %0d, actual %0d",
						name, period - 6, period + 12, elapsed);
					row_failed = 1'b1;
				end
				// The interrupt follows the flag one cycle later.
				step();
				if (status != row.exp_status) begin
					report_mismatch(name, "status", 32'(row.exp_status), 32'(status));
				end
				if (irq_n != row.exp_irq_n) begin
					report_mismatch(name, "irq_n", 32'(row.exp_irq_n), 32'(irq_n));
				end
			end
			SETTLE: begin
				for (int i = 0; i < row.wait_limit && !done; i++) begin
					step();
					done = (status == row.exp_status) && (irq_n == row.exp_irq_n);
				end
				if (status != row.exp_status) begin
					report_mismatch(name, "status", 32'(row.exp_status), 32'(status));
				end
				if (irq_n != row.exp_irq_n) begin
					report_mismatch(name, "irq_n", 32'(row.exp_irq_n), 32'(irq_n));
				end
			end
		endcase
		if (ovf_count != row.exp_ovf) begin
			report_mismatch(name, "overflow_a pulses", row.exp_ovf, ovf_count);
		end
		if (row_failed) begin
			fail_count++;
			$display("Test %s: failed", name);
		end else begin
			pass_count++;
			$display("Test %s: ok", name);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		int total_wait;
		clk   = 1'b0;
		rst_n = 1'b0;
		wr    = 1'b0;
		addr  = '0;
		din   = '0;
		load_table();
		total_wait = 0;
		foreach (table_rows[i]) begin
			total_wait += table_rows[i].wait_limit;
		end
		// Waits, reset and writes with some margin.
		timeout_limit = total_wait + 16 + 200;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		foreach (table_rows[i]) begin
			run_row(i);
		end
		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: ym_timer_top.f
hw/ym_timer_pkg.sv
hw/ym_reg_decoder.sv
hw/ym_clk_prescaler.sv
hw/ym_timer.sv
hw/ym_irq_status.sv
hw/ym_timer_top.sv
sim/ym_timer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module ym_timer_tb -f ym_timer_top.f \
	&& ./obj_dir/Vym_timer_tb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete."; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "Simulation failed."; exit 1; } || echo "Simulation passed."
